/* hw/emu_pkg.sv */
// Shared definitions for the emulator system-control glue
// FSM state types, bus widths and the per-speed PLL tables

`default_nettype none

package emu_pkg;

	// ========================================
	// Bus widths
	// ========================================
	localparam int MGMT_AW = 32;
	localparam int MGMT_DW = 32;
	localparam int CFG_AW  = 6;
	localparam int CFG_DW  = 32;

	// ========================================
	// Speed selection
	// ========================================
	localparam int SPEED_W    = 3;
	localparam int NUM_SPEEDS = 5;

	// PLL counter divider word for each speed
	localparam logic [15:0] SPEED_DIV [NUM_SPEEDS] = '{
		16'h0505, 16'h0504, 16'h1e1e, 16'h0f0f, 16'h0808
	};

	// Resulting core clock rate in Hz
	localparam logic [31:0] CLK_RATE [NUM_SPEEDS] = '{
		32'd90500000, 32'd100555490, 32'd15083323, 32'd30166647, 32'd56562463
	};

	// PLL reconfiguration register map
	localparam logic [CFG_AW-1:0] CFG_ADDR_MODE  = 6'd0;
	localparam logic [CFG_AW-1:0] CFG_ADDR_DIV   = 6'd5;
	localparam logic [CFG_AW-1:0] CFG_ADDR_START = 6'd2;

	// ========================================
	// FSM states
	// ========================================
	typedef enum logic [2:0] {
		MGMT_IDLE,
		MGMT_RD_REQ,
		MGMT_RD_WAIT,
		MGMT_WR_REQ,
		MGMT_WR_DONE
	} mgmt_state_t;

	typedef enum logic [2:0] {
		CFG_IDLE,
		CFG_WR_MODE,
		CFG_GAP_1,
		CFG_WR_DIV,
		CFG_GAP_2,
		CFG_WR_START
	} cfg_state_t;

endpackage

`default_nettype wire

/* hw/hps_mgmt_ctrl.sv */
// Host to management bus bridge
// Each host read or write pulse becomes one bus transaction; io_wait holds the host

`timescale 1ns/1ps
`default_nettype none

module hps_mgmt_ctrl (
	input  wire                          CLK_50M,
	input  wire                          reset,

	// Host side
	input  wire                          host_rd,
	input  wire                          host_wr,
	input  wire  [emu_pkg::MGMT_AW-1:0]  host_addr,
	input  wire  [emu_pkg::MGMT_DW-1:0]  host_wdata,
	output logic [emu_pkg::MGMT_DW-1:0]  host_rdata,
	output logic                         io_wait,

	// Management bus master
	output logic                         mgmt_rd,
	output logic                         mgmt_we,
	output logic [emu_pkg::MGMT_AW-1:0]  mgmt_addr,
	output logic [emu_pkg::MGMT_DW-1:0]  mgmt_wdata,
	input  wire                          mgmt_waitrequest,
	input  wire  [emu_pkg::MGMT_DW-1:0]  mgmt_rdata,
	input  wire                          mgmt_rdvalid
);

	emu_pkg::mgmt_state_t state;

	// ========================================
	// Control FSM
	// ========================================
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			state   <= emu_pkg::MGMT_IDLE;
			io_wait <= 1'b0;
			mgmt_rd <= 1'b0;
			mgmt_we <= 1'b0;
		end else begin
			case (state)
				emu_pkg::MGMT_RD_REQ: begin
					mgmt_we <= 1'b0;
					mgmt_rd <= 1'b1;
					state   <= emu_pkg::MGMT_RD_WAIT;
				end
				emu_pkg::MGMT_RD_WAIT: begin
					// Command leaves the bus once the slave takes it
					if (!mgmt_waitrequest)
						mgmt_rd <= 1'b0;
					if (mgmt_rdvalid) begin
						mgmt_rd <= 1'b0;
						io_wait <= 1'b0;
						state   <= emu_pkg::MGMT_IDLE;
					end
				end
				emu_pkg::MGMT_WR_REQ: begin
					mgmt_rd <= 1'b0;
					mgmt_we <= 1'b1;
					state   <= emu_pkg::MGMT_WR_DONE;
				end
				emu_pkg::MGMT_WR_DONE: begin
					if (!mgmt_waitrequest) begin
						mgmt_we <= 1'b0;
						io_wait <= 1'b0;
						state   <= emu_pkg::MGMT_IDLE;
					end
				end
				default: begin
					state <= emu_pkg::MGMT_IDLE;
				end
			endcase

			// A new host request always restarts the sequence
			if (host_rd) begin
				io_wait <= 1'b1;
				state   <= emu_pkg::MGMT_RD_REQ;
			end else if (host_wr) begin
				io_wait <= 1'b1;
				state   <= emu_pkg::MGMT_WR_REQ;
			end
		end
	end

	// ========================================
	// Address, write data and read data
	// ========================================
	always_ff @(posedge CLK_50M) begin
		if (host_rd || host_wr) begin
			mgmt_addr  <= host_addr;
			mgmt_wdata <= host_wdata;
		end
		if (state == emu_pkg::MGMT_RD_WAIT && mgmt_rdvalid)
			host_rdata <= mgmt_rdata;
	end

	// Read and write never share the bus
	a_rd_we_excl: assert property (
		@(posedge CLK_50M) disable iff (reset)
		!(mgmt_rd && mgmt_we)
	);

	// Host stays stalled while a command or its read data is pending
	a_wait_busy: assert property (
		@(posedge CLK_50M) disable iff (reset)
		(mgmt_rd || mgmt_we || state == emu_pkg::MGMT_RD_WAIT) |-> io_wait
	);

endmodule

`default_nettype wire

/* hw/speed_reconfig.sv */
// Core speed selection filter and PLL reconfiguration sequencer
// Every accepted speed change writes mode, divider and start to the PLL config port

`timescale 1ns/1ps
`default_nettype none

module speed_reconfig (
	input  wire                         CLK_50M,
	input  wire                         reset,
	input  wire  [emu_pkg::SPEED_W-1:0] speed_sel,

	// PLL config port
	output logic                        cfg_write,
	output logic [emu_pkg::CFG_AW-1:0]  cfg_addr,
	output logic [emu_pkg::CFG_DW-1:0]  cfg_data,
	input  wire                         cfg_waitrequest,

	output logic [31:0]                 clk_rate
);

	localparam logic [emu_pkg::SPEED_W-1:0] SPEED_CNT =
		emu_pkg::NUM_SPEEDS[emu_pkg::SPEED_W-1:0];

	logic [emu_pkg::SPEED_W-1:0] sel_q1;
	logic [emu_pkg::SPEED_W-1:0] sel_q2;
	logic [emu_pkg::SPEED_W-1:0] speed;
	logic [emu_pkg::SPEED_W-1:0] old_speed;
	logic                        chg_q;
	logic                        stall;
	emu_pkg::cfg_state_t         state;

	// Write in flight and not yet taken by the PLL
	assign stall = cfg_write & cfg_waitrequest;

	// ========================================
	// Selection filter and change detect
	// ========================================
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			sel_q1    <= '0;
			sel_q2    <= '0;
			speed     <= '0;
			old_speed <= '0;
			chg_q     <= 1'b0;
		end else begin
			sel_q1    <= speed_sel;
			sel_q2    <= sel_q1;
			// Accept only when two samples agree, unknown codes fall back to speed 0
			if (sel_q1 == sel_q2)
				speed <= (sel_q2 < SPEED_CNT) ? sel_q2 : '0;
			old_speed <= speed;
			// Change request held while a write is stalled
			chg_q     <= (speed != old_speed) | (chg_q & stall);
		end
	end

	assign clk_rate = emu_pkg::CLK_RATE[speed];

	// ========================================
	// Config write sequencer
	// ========================================
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			state     <= emu_pkg::CFG_IDLE;
			cfg_write <= 1'b0;
		end else if (!stall) begin
			cfg_write <= 1'b0;
			case (state)
				emu_pkg::CFG_WR_MODE: begin
					cfg_write <= 1'b1;
					state     <= emu_pkg::CFG_GAP_1;
				end
				emu_pkg::CFG_GAP_1:  state <= emu_pkg::CFG_WR_DIV;
				emu_pkg::CFG_WR_DIV: begin
					cfg_write <= 1'b1;
					state     <= emu_pkg::CFG_GAP_2;
				end
				emu_pkg::CFG_GAP_2:  state <= emu_pkg::CFG_WR_START;
				emu_pkg::CFG_WR_START: begin
					cfg_write <= 1'b1;
					state     <= emu_pkg::CFG_IDLE;
				end
				default: state <= emu_pkg::CFG_IDLE;
			endcase
			if (chg_q)
				state <= emu_pkg::CFG_WR_MODE;
		end
	end

	// Address and data follow the step being issued
	always_ff @(posedge CLK_50M) begin
		if (!stall) begin
			case (state)
				emu_pkg::CFG_WR_MODE: begin
					cfg_addr <= emu_pkg::CFG_ADDR_MODE;
					cfg_data <= '0;
				end
				emu_pkg::CFG_WR_DIV: begin
					cfg_addr <= emu_pkg::CFG_ADDR_DIV;
					cfg_data <= {{(emu_pkg::CFG_DW - 16){1'b0}}, emu_pkg::SPEED_DIV[speed]};
				end
				emu_pkg::CFG_WR_START: begin
					cfg_addr <= emu_pkg::CFG_ADDR_START;
					cfg_data <= '0;
				end
				default: ;
			endcase
		end
	end

	// A write waiting on the PLL keeps its address and data
	a_cfg_hold: assert property (
		@(posedge CLK_50M) disable iff (reset)
		stall |=> cfg_write && $stable(cfg_addr) && $stable(cfg_data)
	);

endmodule

`default_nettype wire

/* hw/reset_gen.sv */
// System and CPU reset generation
// Host reset request is stretched; CPU reset adds button and keyboard sources

`timescale 1ns/1ps
`default_nettype none

module reset_gen #(
	parameter int STRETCH_LEN = 8
) (
	input  wire  CLK_50M,
	input  wire  reset,
	input  wire  rst_req,
	input  wire  user_button,
	input  wire  ps2_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	logic                   req_q1;
	logic                   req_q2;
	logic                   req_rise;
	logic                   init_done;
	logic                   cpu_rst_q;
	logic [STRETCH_LEN-1:0] stretch;

	assign req_rise = req_q1 & ~req_q2;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			req_q1    <= 1'b0;
			req_q2    <= 1'b0;
			init_done <= 1'b0;
			cpu_rst_q <= 1'b0;
			stretch   <= '0;
		end else begin
			req_q1    <= rst_req;
			req_q2    <= req_q1;
			cpu_rst_q <= user_button | rst_req | ~ps2_reset_n;
			// Ones shift out of the top, so the MSB stays set for STRETCH_LEN cycles
			if (req_rise) begin
				stretch   <= '1;
				init_done <= 1'b1;
			end else begin
				stretch <= stretch << 1;
			end
		end
	end

	// Held in reset until the host issues its first request
	assign sys_reset = stretch[STRETCH_LEN-1] | ~init_done | reset;
	assign cpu_reset = sys_reset | cpu_rst_q;

	a_stretch: assert property (
		@(posedge CLK_50M) disable iff (reset)
		req_rise |=> sys_reset [*STRETCH_LEN]
	);

endmodule

`default_nettype wire

/* hw/activity_led.sv */
// Activity LED pulse stretcher
// LED stays lit for HOLD_CYCLES after the last active cycle

`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int HOLD_CYCLES = 4500000
) (
	input  wire  CLK_50M,
	input  wire  reset,
	input  wire  activity,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			hold_cnt <= '0;
			led      <= 1'b0;
		end else begin
			led <= (hold_cnt != '0);
			if (activity)
				hold_cnt <= CNT_W'(HOLD_CYCLES);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - CNT_W'(1);
		end
	end

endmodule

`default_nettype wire

/* hw/emu_sys_ctrl.sv */
// Emulator system-control top level
// Bridge, PLL speed sequencer, reset generator and disk activity LEDs

`timescale 1ns/1ps
`default_nettype none

module emu_sys_ctrl #(
	parameter int STRETCH_LEN = 8,
	parameter int HOLD_CYCLES = 4500000
) (
	input  wire                          CLK_50M,
	input  wire                          reset,

	// Host requests
	input  wire                          host_rd,
	input  wire                          host_wr,
	input  wire  [emu_pkg::MGMT_AW-1:0]  host_addr,
	input  wire  [emu_pkg::MGMT_DW-1:0]  host_wdata,
	output logic [emu_pkg::MGMT_DW-1:0]  host_rdata,
	output logic                         io_wait,

	// Management bus
	output logic                         mgmt_rd,
	output logic                         mgmt_we,
	output logic [emu_pkg::MGMT_AW-1:0]  mgmt_addr,
	output logic [emu_pkg::MGMT_DW-1:0]  mgmt_wdata,
	input  wire                          mgmt_waitrequest,
	input  wire  [emu_pkg::MGMT_DW-1:0]  mgmt_rdata,
	input  wire                          mgmt_rdvalid,

	// Speed and PLL config
	input  wire  [emu_pkg::SPEED_W-1:0]  speed_sel,
	output logic                         cfg_write,
	output logic [emu_pkg::CFG_AW-1:0]   cfg_addr,
	output logic [emu_pkg::CFG_DW-1:0]   cfg_data,
	input  wire                          cfg_waitrequest,
	output logic [31:0]                  clk_rate,

	// Resets
	input  wire                          rst_req,
	input  wire                          user_button,
	input  wire                          ps2_reset_n,
	output logic                         sys_reset,
	output logic                         cpu_reset,

	// Disk activity
	input  wire                          disk_device,
	output logic                         led_hdd,
	output logic                         led_fdd
);

	logic hdd_act;
	logic fdd_act;

	// Disk transfers run through the bridge, device picks the LED
	assign hdd_act = io_wait & disk_device;
	assign fdd_act = io_wait & ~disk_device;

	hps_mgmt_ctrl u_mgmt (
		.CLK_50M          (CLK_50M),
		.reset            (reset),
		.host_rd          (host_rd),
		.host_wr          (host_wr),
		.host_addr        (host_addr),
		.host_wdata       (host_wdata),
		.host_rdata       (host_rdata),
		.io_wait          (io_wait),
		.mgmt_rd          (mgmt_rd),
		.mgmt_we          (mgmt_we),
		.mgmt_addr        (mgmt_addr),
		.mgmt_wdata       (mgmt_wdata),
		.mgmt_waitrequest (mgmt_waitrequest),
		.mgmt_rdata       (mgmt_rdata),
		.mgmt_rdvalid     (mgmt_rdvalid)
	);

	speed_reconfig u_speed (
		.CLK_50M         (CLK_50M),
		.reset           (reset),
		.speed_sel       (speed_sel),
		.cfg_write       (cfg_write),
		.cfg_addr        (cfg_addr),
		.cfg_data        (cfg_data),
		.cfg_waitrequest (cfg_waitrequest),
		.clk_rate        (clk_rate)
	);

	reset_gen #(
		.STRETCH_LEN (STRETCH_LEN)
	) u_rst (
		.CLK_50M     (CLK_50M),
		.reset       (reset),
		.rst_req     (rst_req),
		.user_button (user_button),
		.ps2_reset_n (ps2_reset_n),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset)
	);

	activity_led #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_led_hdd (
		.CLK_50M  (CLK_50M),
		.reset    (reset),
		.activity (hdd_act),
		.led      (led_hdd)
	);

	activity_led #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_led_fdd (
		.CLK_50M  (CLK_50M),
		.reset    (reset),
		.activity (fdd_act),
		.led      (led_fdd)
	);

endmodule

`default_nettype wire

/* verification/emu_sys_ctrl_tb.sv */
// Testbench for the emulator system-control top level
// Pattern-driven with bus models for the management and PLL config ports

`timescale 1ns/1ps
`default_nettype none

module emu_sys_ctrl_tb;

	logic CLK_50M = 1'b0;
	logic reset, host_rd, host_wr, mgmt_waitrequest, mgmt_rdvalid, cfg_waitrequest;
	logic rst_req, user_button, ps2_reset_n, disk_device;
	logic [emu_pkg::MGMT_AW-1:0] host_addr, mgmt_addr;
	logic [emu_pkg::MGMT_DW-1:0] host_wdata, host_rdata, mgmt_wdata, mgmt_rdata;
	logic mgmt_rd, mgmt_we, io_wait, cfg_write, sys_reset, cpu_reset, led_hdd, led_fdd;
	logic [emu_pkg::SPEED_W-1:0] speed_sel;
	logic [emu_pkg::CFG_AW-1:0] cfg_addr;
	logic [emu_pkg::CFG_DW-1:0] cfg_data;
	logic [31:0] clk_rate;

	// Bus model state
	logic [31:0] lcg_state = 32'h983e;
	logic [31:0] cur_data, rd_addr_seen, wr_addr_seen, wr_data_seen;
	int rd_lat, wr_count, n_pat, err_count;
	logic [emu_pkg::CFG_AW-1:0] cfg_addr_q[$];
	logic [emu_pkg::CFG_DW-1:0] cfg_data_q[$];
	logic hdd_seen, fdd_seen;

	// Pattern storage
	string op_q[$];
	logic [31:0] a_q[$], d_q[$], x_q[$];

	emu_sys_ctrl #(.HOLD_CYCLES(40)) u_dut (.*);

	always #10 CLK_50M = ~CLK_50M;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ========================================
	// Management slave and PLL config models
	// ========================================
	always @(posedge CLK_50M) begin
		if (!reset) begin
			if (mgmt_rd && !mgmt_waitrequest) begin
				rd_addr_seen = mgmt_addr;
				rd_lat = 1 + int'(lcg_state[21:20] % 2'd3);
			end else if (rd_lat != 0) begin
				rd_lat = rd_lat - 1;
			end
			if (mgmt_we && !mgmt_waitrequest) begin
				wr_count = wr_count + 1;
				wr_addr_seen = mgmt_addr;
				wr_data_seen = mgmt_wdata;
			end
			if (cfg_write && !cfg_waitrequest) begin
				cfg_addr_q.push_back(cfg_addr);
				cfg_data_q.push_back(cfg_data);
			end
		end
		lcg_state = lcg_next(lcg_state);
		#2;
		mgmt_waitrequest = !reset && lcg_state[16] && lcg_state[17];
		cfg_waitrequest = !reset && lcg_state[18];
		mgmt_rdvalid = (rd_lat == 1);
		mgmt_rdata = cur_data;
	end

	// ========================================
	// Checks
	// ========================================
	task automatic abort_run(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input string what, input logic [emu_pkg::MGMT_DW-1:0] got,
			input logic [emu_pkg::MGMT_DW-1:0] exp);
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_cfg(input logic [emu_pkg::CFG_AW-1:0] got_addr,
			input logic [emu_pkg::CFG_DW-1:0] got_data,
			input logic [emu_pkg::CFG_AW-1:0] exp_addr,
			input logic [emu_pkg::CFG_DW-1:0] exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			err_count = err_count + 1;
			$display("[FAIL] %0t ns: config write %h/%h expected %h/%h", $time,
				got_addr, got_data, exp_addr, exp_data);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	// ========================================
	// Stimulus helpers
	// ========================================
	task automatic next_cycle();
		@(posedge CLK_50M);
		#2;
	endtask

	// One host request; returns at the first sample with io_wait low
	task automatic host_request(input logic is_read, input logic [31:0] addr,
			input logic [31:0] data);
		int n;
		n = 0;
		hdd_seen = 1'b0;
		fdd_seen = 1'b0;
		host_addr = addr;
		host_wdata = data;
		host_rd = is_read;
		host_wr = !is_read;
		next_cycle();
		host_rd = 1'b0;
		host_wr = 1'b0;
		if (!io_wait)
			abort_run("io_wait did not rise after the host request");
		while (io_wait && n < 100) begin
			hdd_seen = hdd_seen | led_hdd;
			fdd_seen = fdd_seen | led_fdd;
			next_cycle();
			n = n + 1;
		end
		if (io_wait)
			abort_run("the bridge never released io_wait");
	endtask

	task automatic run_speed(input logic [31:0] div, input logic [31:0] rate,
			input logic [31:0] code);
		int n;
		n = 0;
		cfg_addr_q.delete();
		cfg_data_q.delete();
		speed_sel = code[emu_pkg::SPEED_W-1:0];
		while (cfg_addr_q.size() == 0 && n < 100) begin
			next_cycle();
			n = n + 1;
		end
		if (cfg_addr_q.size() == 0)
			abort_run("no PLL config write after a speed change");
		check_data("clk_rate", clk_rate, rate);
		repeat (30) next_cycle();
		check_data("config write count", 32'(cfg_addr_q.size()), 32'd3);
		check_cfg(cfg_addr_q[0], cfg_data_q[0], 6'd0, 32'd0);
		check_cfg(cfg_addr_q[1], cfg_data_q[1], 6'd5, {16'd0, div[15:0]});
		check_cfg(cfg_addr_q[2], cfg_data_q[2], 6'd2, 32'd0);
	endtask

	task automatic run_reset(input logic [31:0] len, input logic ps2_n);
		logic hist [24];
		int first, run;
		first = -1;
		run = 0;
		// Single-cycle request pulse, later cycles leave only the keyboard source
		rst_req = 1'b1;
		ps2_reset_n = ps2_n;
		for (int i = 0; i < 24; i++) begin
			next_cycle();
			rst_req = 1'b0;
			hist[i] = sys_reset;
			if (sys_reset || !ps2_n)
				check_bit("cpu_reset", cpu_reset, 1'b1);
			else if (i > 0)
				check_bit("cpu_reset with no reset source", cpu_reset, 1'b0);
		end
		for (int i = 0; i < 24; i++) begin
			if (hist[i] && first < 0)
				first = i;
			if (first >= 0 && hist[i] && run == i - first)
				run = run + 1;
		end
		check_data("sys_reset stretch", 32'(run), len);
		ps2_reset_n = 1'b1;
		repeat (4) next_cycle();
	endtask

	task automatic run_led(input logic [31:0] addr, input logic [31:0] data, input logic dev);
		int n;
		n = 0;
		while ((led_hdd || led_fdd) && n < 60) begin
			next_cycle();
			n = n + 1;
		end
		disk_device = dev;
		cur_data = data;
		host_request(1'b1, addr, data);
		check_bit("selected LED during read", dev ? hdd_seen : fdd_seen, 1'b1);
		check_bit("other LED during read", dev ? fdd_seen : hdd_seen, 1'b0);
		n = 0;
		while ((dev ? led_hdd : led_fdd) && n < 60) begin
			next_cycle();
			n = n + 1;
		end
		check_bit("LED hold between 40 and 43 cycles", n >= 40 && n <= 43, 1'b1);
		disk_device = 1'b0;
	endtask

	// ========================================
	// Pattern reader and main sequence
	// ========================================
	initial begin
		int fd, cnt;
		string line, op;
		logic [31:0] fa, fdat, fx;
		reset = 1'b1;
		{host_rd, host_wr, host_addr, host_wdata} = '0;
		{mgmt_waitrequest, mgmt_rdvalid, mgmt_rdata, cfg_waitrequest} = '0;
		{rst_req, user_button, disk_device, speed_sel} = '0;
		ps2_reset_n = 1'b1;
		{cur_data, rd_lat, wr_count, err_count, n_pat} = '0;
		fd = $fopen("verification/emu_sys_ctrl_patterns.txt", "r");
		if (fd == 0)
			abort_run("cannot open the pattern file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				cnt = $sscanf(line, "%s %h %h %h", op, fa, fdat, fx);
				if (cnt != 4)
					abort_run("malformed pattern line");
				op_q.push_back(op);
				a_q.push_back(fa);
				d_q.push_back(fdat);
				x_q.push_back(fx);
			end
		end
		$fclose(fd);
		n_pat = op_q.size();
		repeat (10) next_cycle();
		reset = 1'b0;
		// The system stays in reset until the host sends its first request
		rst_req = 1'b1;
		repeat (4) next_cycle();
		rst_req = 1'b0;
		repeat (20) next_cycle();
		check_bit("sys_reset after first request", sys_reset, 1'b0);
		foreach (op_q[i]) begin
			case (op_q[i])
				"READ": begin
					cur_data = d_q[i];
					host_request(1'b1, a_q[i], d_q[i]);
					check_data("read data", host_rdata, d_q[i]);
					check_data("read address", rd_addr_seen, a_q[i]);
				end
				"WRITE": begin
					wr_count = 0;
					host_request(1'b0, a_q[i], d_q[i]);
					repeat (3) next_cycle();
					check_data("write count", 32'(wr_count), 32'd1);
					check_data("write address", wr_addr_seen, a_q[i]);
					check_data("write data", wr_data_seen, d_q[i]);
				end
				"SPEED": run_speed(a_q[i], d_q[i], x_q[i]);
				"RESET": run_reset(d_q[i], x_q[i][0]);
				"LED":   run_led(a_q[i], d_q[i], x_q[i][0]);
				default: abort_run({"unknown opcode ", op_q[i]});
			endcase
		end
		if (err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog sized from the number of patterns
	initial begin
		wait (n_pat > 0);
		#((n_pat * 200 + 100) * 20);
		$display("Error: watchdog expired before all patterns finished");
		$display("TEST FAIL");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* emu_sys_ctrl.f */
hw/emu_pkg.sv
hw/hps_mgmt_ctrl.sv
hw/speed_reconfig.sv
hw/reset_gen.sv
hw/activity_led.sv
hw/emu_sys_ctrl.sv
verification/emu_sys_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := emu_sys_ctrl_tb
FILELIST  := emu_sys_ctrl.f
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
DATA := verification/emu_sys_ctrl_patterns.txt
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN) $(DATA)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/emu_sys_ctrl_patterns.txt */
# op    addr/div  data/rate/len  arg (speed code, disk_device or ps2_reset_n), all hex
# READ/WRITE/LED use addr and data; SPEED gives divider word and clk_rate; RESET gives stretch
READ   00001000  cafef00d  0
WRITE  00002004  12345678  0
READ   00002004  deadbeef  0
WRITE  0000fffc  a5a55a5a  0
SPEED  00001e1e  00e6273b  2
READ   00000040  00c0ffee  0
SPEED  00000f0f  01cc4e77  3
SPEED  00000504  05fe5ae2  1
SPEED  00000505  0564eba0  7
SPEED  00000808  035f131f  4
RESET  00000000  00000008  1
RESET  00000000  00000008  0
LED    00003000  11223344  1
LED    00003004  55667788  0
WRITE  00000010  0badcafe  0
READ   00000010  87654321  0
